// File: verilog.f
hw/scc_pkg.sv
hw/scc_channel.sv
hw/scc_regs.sv
hw/scc.sv
hw/scc_iigs_wrapper.sv
bench/tb_scc_iigs.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the SCC testbench under Verilator

cd "$(dirname "$0")" || exit 1

top=tb_scc_iigs
build_dir=obj_dir
log=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module "$top" -Mdir "$build_dir" -o "$top" -f verilog.f; then
    echo "FAIL: Verilator build did not complete"
    exit 1
fi

if ! "./$build_dir/$top" > "$log" 2>&1; then
    cat "$log"
    echo "FAIL: simulation exited with an error"
    exit 1
fi

cat "$log"

if grep -q "all tests passed" "$log"; then
    echo "PASS"
    exit 0
else
    echo "FAIL: pass message not found in $log"
    exit 1
fi

// File: bench/tb_scc_iigs.sv
`timescale 1ns/1ps

module tb_scc_iigs;
    import scc_pkg::*;

    localparam int CLK_PERIOD = 40;     // Bench master clock, ns
    localparam int N_TESTS    = 6;
    localparam logic [7:0] TC_A = 8'd1; // Channel A loopback time constant
    localparam logic [7:0] TC_B = 8'd3;

    logic       clk_14m;
    logic       reset;
    logic       ph2_en;
    logic [1:0] ph2_cnt;
    logic       cs;
    logic       we;
    logic [1:0] rs;
    logic [7:0] wdata;
    logic       rxd_a;
    logic       rxd_b;
    logic       cts_a;
    logic       cts_b;
    logic [7:0] rdata;
    logic       irq_n;
    logic       txd_a;
    logic       txd_b;
    logic       rts_a;
    logic       rts_b;
    logic       loop_en;                // Serial loopback switch
    logic [1:0] exp_rts;                // Expected WR5 RTS, 1 = A, 0 = B
    integer     seed;
    int         errors;
    int         checks;

    assign rxd_a = loop_en ? txd_a : 1'b1;  // Idle line when open
    assign rxd_b = loop_en ? txd_b : 1'b1;

    scc_iigs_wrapper DUT (
        .clk_14m (clk_14m), .reset (reset), .ph2_en (ph2_en),
        .cs (cs), .we (we), .rs (rs), .wdata (wdata),
        .rxd_a (rxd_a), .rxd_b (rxd_b), .cts_a (cts_a), .cts_b (cts_b),
        .rdata (rdata), .irq_n (irq_n),
        .txd_a (txd_a), .txd_b (txd_b), .rts_a (rts_a), .rts_b (rts_b)
    );

    initial begin
        clk_14m = 1'b0;
        forever #(CLK_PERIOD / 2) clk_14m = ~clk_14m;
    end

    // CPU phase strobe, one cycle in four
    initial begin
        ph2_cnt = 2'd0;
        ph2_en  = 1'b0;
        forever begin
            @(negedge clk_14m);
            ph2_cnt <= ph2_cnt + 2'd1;
            ph2_en  <= (ph2_cnt == 2'd2);
        end
    end

    // Pins held at their idle levels through reset
    assert property (@(posedge clk_14m) reset |-> (irq_n && txd_a && txd_b && rts_a && rts_b))
        else begin
            errors++;
            $display("error reset_pins expected 1f got %h", {irq_n, txd_a, txd_b, rts_a, rts_b});
        end

    // RTS pins follow WR5 inverted
    assert property (@(posedge clk_14m) disable iff (reset) rts_a == !exp_rts[1])
        else begin
            errors++;
            $display("error rts_a expected %h got %h", !exp_rts[1], rts_a);
        end

    assert property (@(posedge clk_14m) disable iff (reset) rts_b == !exp_rts[0])
        else begin
            errors++;
            $display("error rts_b expected %h got %h", !exp_rts[0], rts_b);
        end

    task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("error %s expected %h got %h", name, exp, act);
        end
    endtask

    // One CPU access, cs held for exactly one ph2 pulse
    task automatic bus_access(input logic wr, input logic [1:0] sel, input logic [7:0] din,
                              output logic [7:0] dout);
        @(negedge clk_14m);
        while (ph2_cnt != 2'd2) @(negedge clk_14m);  // ph2_en rises on this edge
        cs    <= 1'b1;
        we    <= wr;
        rs    <= sel;
        wdata <= din;
        #(CLK_PERIOD / 4);
        dout = rdata;                   // Settled, before the access edge
        @(posedge clk_14m);             // Access edge
        @(negedge clk_14m);
        cs <= 1'b0;
        we <= 1'b0;
    endtask

    task automatic ctrl_write(input logic ch, input scc_reg_e r, input logic [7:0] v);
        logic [7:0] unused_q;
        if (r != REG0) bus_access(1'b1, {1'b0, ch}, {4'h0, r}, unused_q);  // Pointer first
        bus_access(1'b1, {1'b0, ch}, v, unused_q);
        if (r == REG5) exp_rts[ch] = v[WR5_RTS];
    endtask

    task automatic ctrl_read(input logic ch, input scc_reg_e r, output logic [7:0] q);
        logic [7:0] unused_q;
        if (r != REG0) bus_access(1'b1, {1'b0, ch}, {4'h0, r}, unused_q);
        bus_access(1'b0, {1'b0, ch}, 8'h00, q);
    endtask

    task automatic data_write(input logic ch, input logic [7:0] v);
        logic [7:0] unused_q;
        bus_access(1'b1, {1'b1, ch}, v, unused_q);
    endtask

    task automatic data_read(input logic ch, output logic [7:0] q);
        bus_access(1'b0, {1'b1, ch}, 8'h00, q);  // Pops the holding register
    endtask

    task automatic wait_tx_empty(input logic ch);
        logic [7:0] q;
        do ctrl_read(ch, REG0, q); while (!q[RR0_TX_EMPTY]);
    endtask

    task automatic wait_rx_avail(input logic ch);
        logic [7:0] q;
        do ctrl_read(ch, REG0, q); while (!q[RR0_RX_AVAIL]);
    endtask

    task automatic send_byte(input logic ch, input logic [7:0] v);
        wait_tx_empty(ch);              // Bytes written while busy are dropped
        data_write(ch, v);
    endtask

    task automatic wait_irq_high();
        int n;
        n = 0;
        while (irq_n !== 1'b1 && n < 8) begin   // Registered pin lags a cycle
            @(negedge clk_14m);
            n++;
        end
    endtask

    // Eight random frames through the loopback, A's receiver watched on B runs
    task automatic run_loopback(input logic ch, input logic [7:0] tc);
        logic [7:0] b;
        logic [7:0] q;
        ctrl_write(ch, REG12, tc);
        ctrl_write(ch, REG3, 8'(1 << WR3_RX_EN));
        ctrl_write(ch, REG5, 8'(1 << WR5_TX_EN));
        for (int i = 0; i < 8; i++) begin
            b = 8'($random(seed));
            send_byte(ch, b);
            wait_rx_avail(ch);
            data_read(ch, q);
            check_val(ch ? "rx_data_a" : "rx_data_b", b, q);
            ctrl_read(ch, REG0, q);
            check_val("rr0_rx_avail", 8'h00, {7'b0, q[RR0_RX_AVAIL]});
            if (!ch) begin
                ctrl_read(1'b1, REG0, q);
                check_val("rr0_a_rx_avail", 8'h00, {7'b0, q[RR0_RX_AVAIL]});
            end
        end
    endtask

    // Watchdog, 20 frames per test at the slower baud rate
    initial begin
        int frame_ns;
        int limit_ns;
        frame_ns = 10 * (int'(TC_B) + 1) * DUT.PCLK_DIV * CLK_PERIOD;
        limit_ns = 20 * N_TESTS * frame_ns;
        #(limit_ns);
        $display("timeout, the run did not finish within %0d ns", limit_ns);
        $display("tests failed");
        $finish;
    end

    initial begin
        logic [7:0] q;
        logic [7:0] tc_a;
        logic [7:0] tc_b;
        logic [7:0] b;
        logic [7:0] b2;
        int         n;
        reset   = 1'b1;
        cs      = 1'b0;
        we      = 1'b0;
        rs      = 2'b00;
        wdata   = 8'h00;
        cts_a   = 1'b0;
        cts_b   = 1'b0;
        loop_en = 1'b0;
        exp_rts = 2'b00;
        seed    = 73371;
        errors  = 0;
        checks  = 0;
        repeat (8) @(negedge clk_14m);
        reset <= 1'b0;
        @(negedge clk_14m);

        // Idle state after reset
        check_val("irq_n", 8'h01, {7'b0, irq_n});
        check_val("txd_a", 8'h01, {7'b0, txd_a});
        check_val("txd_b", 8'h01, {7'b0, txd_b});
        check_val("rts_a", 8'h01, {7'b0, rts_a});
        check_val("rts_b", 8'h01, {7'b0, rts_b});
        ctrl_read(1'b1, REG0, q);
        check_val("rr0_a", 8'(1 << RR0_TX_EMPTY), q);
        ctrl_read(1'b0, REG0, q);
        check_val("rr0_b", 8'(1 << RR0_TX_EMPTY), q);

        // WR12 per channel, pointer back at 0 afterwards
        tc_a = 8'($random(seed));
        tc_b = 8'($random(seed));
        ctrl_write(1'b1, REG12, tc_a);
        ctrl_write(1'b0, REG12, tc_b);
        ctrl_read(1'b1, REG12, q);
        check_val("rr12_a", tc_a, q);
        ctrl_read(1'b1, REG0, q);
        check_val("rr0_a", 8'(1 << RR0_TX_EMPTY), q);
        ctrl_read(1'b0, REG12, q);
        check_val("rr12_b", tc_b, q);
        ctrl_read(1'b0, REG0, q);
        check_val("rr0_b", 8'(1 << RR0_TX_EMPTY), q);

        loop_en = 1'b1;
        run_loopback(1'b1, TC_A);
        run_loopback(1'b0, TC_B);

        // Receive interrupt on channel A
        ctrl_write(1'b1, REG1, 8'(1 << WR1_RX_IE));
        ctrl_write(1'b1, REG9, 8'(1 << WR9_MIE));
        check_val("irq_n", 8'h01, {7'b0, irq_n});
        b = 8'($random(seed));
        send_byte(1'b1, b);
        while (irq_n !== 1'b0) @(negedge clk_14m);
        ctrl_read(1'b1, REG3, q);
        check_val("rr3", 8'h20, q);
        data_read(1'b1, q);
        check_val("rx_data_a", b, q);
        wait_irq_high();
        check_val("irq_n", 8'h01, {7'b0, irq_n});

        // Transmit interrupt, cleared by the next data write
        wait_tx_empty(1'b1);
        ctrl_write(1'b1, REG1, 8'(1 << WR1_TX_IE));
        b = 8'($random(seed));
        data_write(1'b1, b);
        while (irq_n !== 1'b0) @(negedge clk_14m);
        ctrl_read(1'b1, REG3, q);
        check_val("rr3", 8'h10, q);
        data_read(1'b1, q);
        check_val("rx_data_a", b, q);
        b2 = 8'($random(seed));
        data_write(1'b1, b2);
        wait_irq_high();
        check_val("irq_n", 8'h01, {7'b0, irq_n});
        wait_tx_empty(1'b1);
        wait_rx_avail(1'b1);
        data_read(1'b1, q);
        check_val("rx_data_a", b2, q);
        ctrl_write(1'b1, REG1, 8'h00);
        ctrl_write(1'b1, REG9, 8'h00);
        wait_irq_high();
        check_val("irq_n", 8'h01, {7'b0, irq_n});

        // RTS per channel
        ctrl_write(1'b1, REG5, 8'((1 << WR5_TX_EN) | (1 << WR5_RTS)));
        check_val("rts_a", 8'h00, {7'b0, rts_a});
        check_val("rts_b", 8'h01, {7'b0, rts_b});
        ctrl_write(1'b1, REG5, 8'(1 << WR5_TX_EN));
        check_val("rts_a", 8'h01, {7'b0, rts_a});
        ctrl_write(1'b0, REG5, 8'((1 << WR5_TX_EN) | (1 << WR5_RTS)));
        check_val("rts_b", 8'h00, {7'b0, rts_b});
        check_val("rts_a", 8'h01, {7'b0, rts_a});
        ctrl_write(1'b0, REG5, 8'(1 << WR5_TX_EN));
        check_val("rts_b", 8'h01, {7'b0, rts_b});

        // CTS through the synchronizer into RR0
        @(negedge clk_14m);
        cts_a <= 1'b1;
        n = 0;
        do begin
            ctrl_read(1'b1, REG0, q);
            n++;
        end while (!q[RR0_CTS] && n < 8);
        check_val("rr0_a_cts", 8'h01, {7'b0, q[RR0_CTS]});
        ctrl_read(1'b0, REG0, q);
        check_val("rr0_b_cts", 8'h00, {7'b0, q[RR0_CTS]});
        @(negedge clk_14m);
        cts_a <= 1'b0;
        cts_b <= 1'b1;
        n = 0;
        do begin
            ctrl_read(1'b0, REG0, q);
            n++;
        end while (!q[RR0_CTS] && n < 8);
        check_val("rr0_b_cts", 8'h01, {7'b0, q[RR0_CTS]});
        ctrl_read(1'b1, REG0, q);
        check_val("rr0_a_cts", 8'h00, {7'b0, q[RR0_CTS]});

        repeat (4) @(negedge clk_14m);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: hw/scc_iigs_wrapper.sv
`timescale 1ns/1ps

// C038..C03B window, rs[1] data/control, rs[0] channel A/B
module scc_iigs_wrapper #(
    parameter int PCLK_DIV = 8          // Master clocks per PCLK tick
) (
    input  logic       clk_14m,
    input  logic       reset,
    input  logic       ph2_en,          // CPU bus phase strobe
    input  logic       cs,
    input  logic       we,
    input  logic [1:0] rs,
    input  logic [7:0] wdata,
    input  logic       rxd_a,           // Printer port
    input  logic       rxd_b,           // Modem port
    input  logic       cts_a,
    input  logic       cts_b,
    output logic [7:0] rdata,
    output logic       irq_n,
    output logic       txd_a,
    output logic       txd_b,
    output logic       rts_a,
    output logic       rts_b
);

    localparam int CNT_W = (PCLK_DIV > 1) ? $clog2(PCLK_DIV) : 1;

    logic [CNT_W-1:0] div_cnt;
    logic             pclk_en;

    // Free running PCLK divider, wraps at PCLK_DIV-1
    always_ff @(posedge clk_14m or posedge reset) begin
        if (reset) begin
            div_cnt <= '0;
        end else if (div_cnt == CNT_W'(PCLK_DIV - 1)) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign pclk_en = (div_cnt == '0);   // One tick per PCLK_DIV cycles

    scc scc_inst (
        .clk_14m (clk_14m),
        .reset   (reset),
        .pclk_en (pclk_en),
        .ph2_en  (ph2_en),
        .cs      (cs),
        .we      (we),
        .rs      (rs),
        .wdata   (wdata),
        .rxd_a   (rxd_a),
        .rxd_b   (rxd_b),
        .cts_a   (cts_a),
        .cts_b   (cts_b),
        .rdata   (rdata),
        .irq_n   (irq_n),
        .txd_a   (txd_a),
        .txd_b   (txd_b),
        .rts_a   (rts_a),
        .rts_b   (rts_b)
    );

endmodule

// File: hw/scc.sv
`timescale 1ns/1ps

module scc (
    input  logic       clk_14m,
    input  logic       reset,
    input  logic       pclk_en,
    input  logic       ph2_en,
    input  logic       cs,
    input  logic       we,
    input  logic [1:0] rs,
    input  logic [7:0] wdata,
    input  logic       rxd_a,
    input  logic       rxd_b,
    input  logic       cts_a,
    input  logic       cts_b,
    output logic [7:0] rdata,
    output logic       irq_n,
    output logic       txd_a,
    output logic       txd_b,
    output logic       rts_a,
    output logic       rts_b
);
    import scc_pkg::*;

    scc_chan_cfg_t  cfg_a;
    scc_chan_cfg_t  cfg_b;
    scc_chan_stat_t stat_a;
    scc_chan_stat_t stat_b;
    logic [7:0]     tx_byte;
    logic           irq_level;
    logic           data_rd;
    logic           rd_pop_a;
    logic           rd_pop_b;

    // Data register read pops the holding register of that channel
    assign data_rd  = cs && ph2_en && !we && rs[1];
    assign rd_pop_a = data_rd && rs[0];
    assign rd_pop_b = data_rd && !rs[0];

    // Registered pin, no glitches while pending bits settle
    always_ff @(posedge clk_14m or posedge reset) begin
        if (reset) begin
            irq_n <= 1'b1;
        end else begin
            irq_n <= !irq_level;
        end
    end

    scc_regs regs (
        .clk_14m (clk_14m), .reset (reset), .ph2_en (ph2_en),
        .cs (cs), .we (we), .rs (rs), .wdata (wdata),
        .stat_a (stat_a), .stat_b (stat_b),
        .rdata (rdata), .cfg_a (cfg_a), .cfg_b (cfg_b),
        .tx_byte (tx_byte), .irq_level (irq_level)
    );

    scc_channel chan_a (
        .clk_14m (clk_14m), .reset (reset), .pclk_en (pclk_en),
        .cfg (cfg_a), .tx_byte (tx_byte), .rd_pop (rd_pop_a),
        .rxd (rxd_a), .cts (cts_a),
        .stat (stat_a), .txd (txd_a), .rts (rts_a)
    );

    scc_channel chan_b (
        .clk_14m (clk_14m), .reset (reset), .pclk_en (pclk_en),
        .cfg (cfg_b), .tx_byte (tx_byte), .rd_pop (rd_pop_b),
        .rxd (rxd_b), .cts (cts_b),
        .stat (stat_b), .txd (txd_b), .rts (rts_b)
    );

endmodule

// File: hw/scc_regs.sv
`timescale 1ns/1ps

module scc_regs (
    input  logic                    clk_14m,
    input  logic                    reset,
    input  logic                    ph2_en,
    input  logic                    cs,
    input  logic                    we,
    input  logic [1:0]              rs,
    input  logic [7:0]              wdata,
    input  scc_pkg::scc_chan_stat_t stat_a,
    input  scc_pkg::scc_chan_stat_t stat_b,
    output logic [7:0]              rdata,
    output scc_pkg::scc_chan_cfg_t  cfg_a,
    output scc_pkg::scc_chan_cfg_t  cfg_b,
    output logic [7:0]              tx_byte,
    output logic                    irq_level
);
    import scc_pkg::*;

    logic                  access;
    logic                  ch;          // 1 = channel A, 0 = channel B
    logic                  data_wr;
    logic [3:0]            ptr;         // Shared by both channels
    logic [1:0][7:0]       wr1;
    logic [1:0][7:0]       wr3;
    logic [1:0][7:0]       wr5;
    logic [1:0][7:0]       wr12;
    logic [7:0]            wr9;
    logic [1:0]            tx_load_q;
    logic [1:0]            tx_empty_q;
    logic [1:0]            tx_pend;
    logic [1:0]            rx_pend;
    logic [7:0]            rr3;
    scc_chan_stat_t [1:0]  st;

    function automatic logic [7:0] rr0_of(input scc_chan_stat_t s);
        logic [7:0] r;
        r = '0;
        r[RR0_RX_AVAIL] = s.rx_avail;
        r[RR0_TX_EMPTY] = s.tx_empty;
        r[RR0_CTS]      = s.cts;
        return r;
    endfunction

    assign access  = cs && ph2_en;
    assign ch      = rs[0];
    assign data_wr = access && we && rs[1];
    assign st[1]   = stat_a;            // Index by rs[0]
    assign st[0]   = stat_b;

    // Pointer and write registers
    always_ff @(posedge clk_14m or posedge reset) begin
        if (reset) begin
            ptr  <= '0;
            wr1  <= '0;
            wr3  <= '0;
            wr5  <= '0;
            wr12 <= '0;
            wr9  <= '0;
        end else if (access && !rs[1]) begin
            if (we && ptr == 4'd0) begin
                ptr <= wdata[3:0];          // WR0 selects next register
            end else begin
                ptr <= 4'd0;                // Any reach returns to WR0/RR0
                if (we) begin
                    case (scc_reg_e'(ptr))
                        REG1:    wr1[ch]  <= wdata;
                        REG3:    wr3[ch]  <= wdata;
                        REG5:    wr5[ch]  <= wdata;
                        REG9:    wr9      <= wdata;  // Shared
                        REG12:   wr12[ch] <= wdata;
                        default: ;                   // Unimplemented register
                    endcase
                end
            end
        end
    end

    // Load strobe one cycle after the data write, byte held alongside
    always_ff @(posedge clk_14m or posedge reset) begin
        if (reset) begin
            tx_load_q <= '0;
        end else begin
            tx_load_q <= '0;
            if (data_wr) begin
                tx_load_q[ch] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_14m) begin
        if (data_wr) begin
            tx_byte <= wdata;
        end
    end

    // Transmit pending on tx_empty rising edge
    always_ff @(posedge clk_14m or posedge reset) begin
        if (reset) begin
            tx_empty_q <= '1;               // Transmitters come up empty
            tx_pend    <= '0;
        end else begin
            for (int c = 0; c < 2; c++) begin
                tx_empty_q[c] <= st[c].tx_empty;
                if (!wr1[c][WR1_TX_IE] || (data_wr && ch == 1'(c))) begin
                    tx_pend[c] <= 1'b0;
                end else if (st[c].tx_empty && !tx_empty_q[c]) begin
                    tx_pend[c] <= 1'b1;
                end
            end
        end
    end

    assign rx_pend = {st[1].rx_avail && wr1[1][WR1_RX_IE],
                      st[0].rx_avail && wr1[0][WR1_RX_IE]};
    assign rr3     = {2'b00, rx_pend[1], tx_pend[1], 1'b0, rx_pend[0], tx_pend[0], 1'b0};
    assign irq_level = wr9[WR9_MIE] && (|rx_pend || |tx_pend);

    // Read mux, valid while cs is high
    always_comb begin
        rdata = 8'h00;
        if (cs) begin
            if (rs[1]) begin
                rdata = st[ch].rx_byte;     // Data register
            end else begin
                case (scc_reg_e'(ptr))
                    REG0:    rdata = rr0_of(st[ch]);
                    REG3:    rdata = ch ? rr3 : 8'h00;   // B side reads 0
                    REG12:   rdata = wr12[ch];
                    default: rdata = 8'h00;
                endcase
            end
        end
    end

    always_comb begin
        cfg_a.tx_en      = wr5[1][WR5_TX_EN];
        cfg_a.rx_en      = wr3[1][WR3_RX_EN];
        cfg_a.rts        = wr5[1][WR5_RTS];
        cfg_a.time_const = wr12[1];
        cfg_a.tx_load    = tx_load_q[1];
        cfg_b.tx_en      = wr5[0][WR5_TX_EN];
        cfg_b.rx_en      = wr3[0][WR3_RX_EN];
        cfg_b.rts        = wr5[0][WR5_RTS];
        cfg_b.time_const = wr12[0];
        cfg_b.tx_load    = tx_load_q[0];
    end

endmodule

// File: hw/scc_channel.sv
`timescale 1ns/1ps

// One async channel, 8N1 LSB first
module scc_channel (
    input  logic                    clk_14m,
    input  logic                    reset,
    input  logic                    pclk_en,
    input  scc_pkg::scc_chan_cfg_t  cfg,
    input  logic [7:0]              tx_byte,
    input  logic                    rd_pop,
    input  logic                    rxd,
    input  logic                    cts,
    output scc_pkg::scc_chan_stat_t stat,
    output logic                    txd,
    output logic                    rts
);
    import scc_pkg::*;

    logic [7:0] baud_cnt;
    logic       bit_tick;
    tx_state_e  tx_state;
    logic [7:0] tx_data;
    logic [2:0] tx_bit;
    logic       tx_empty;
    logic       tx_accept;
    logic       tx_next_bit;
    rx_state_e  rx_state;
    logic [7:0] rx_cnt;
    logic [7:0] rx_shift;
    logic [7:0] rx_hold;
    logic [2:0] rx_bit;
    logic       rx_avail;
    logic       rx_done;
    logic       rx_fall;
    logic       rx_sample;
    logic       rxd_m;
    logic       rxd_s;
    logic       rxd_d;
    logic       cts_m;
    logic       cts_s;

    // Input synchronizers, line idles high
    always_ff @(posedge clk_14m or posedge reset) begin
        if (reset) begin
            rxd_m <= 1'b1;
            rxd_s <= 1'b1;
            rxd_d <= 1'b1;
            cts_m <= 1'b0;
            cts_s <= 1'b0;
        end else begin
            rxd_m <= rxd;
            rxd_s <= rxd_m;
            rxd_d <= rxd_s;                 // Previous level for edge detect
            cts_m <= cts;
            cts_s <= cts_m;
        end
    end

    // Transmit baud counter, reload on each bit tick
    always_ff @(posedge clk_14m or posedge reset) begin
        if (reset) begin
            baud_cnt <= '0;
        end else if (pclk_en) begin
            if (baud_cnt == 8'd0) begin
                baud_cnt <= cfg.time_const;
            end else begin
                baud_cnt <= baud_cnt - 8'd1;
            end
        end
    end

    assign bit_tick    = pclk_en && (baud_cnt == 8'd0);
    assign tx_accept   = cfg.tx_load && cfg.tx_en && tx_empty;  // Dropped while busy
    assign tx_next_bit = bit_tick && (tx_state == TX_START ||
                                      (tx_state == TX_DATA && tx_bit != 3'd7));

    always_ff @(posedge clk_14m) begin
        if (tx_accept) begin
            tx_data <= tx_byte;
        end else if (tx_next_bit) begin
            tx_data <= {1'b0, tx_data[7:1]};  // LSB goes out first
        end
    end

    always_ff @(posedge clk_14m or posedge reset) begin
        if (reset) begin
            tx_state <= TX_IDLE;
            tx_bit   <= '0;
            tx_empty <= 1'b1;
            txd      <= 1'b1;
        end else begin
            if (tx_accept) tx_empty <= 1'b0;
            if (bit_tick) begin
                case (tx_state)
                    TX_IDLE: begin
                        if (!tx_empty) begin
                            txd      <= 1'b0;       // Start bit
                            tx_state <= TX_START;
                        end
                    end
                    TX_START: begin
                        txd      <= tx_data[0];
                        tx_bit   <= 3'd0;
                        tx_state <= TX_DATA;
                    end
                    TX_DATA: begin
                        if (tx_bit == 3'd7) begin
                            txd      <= 1'b1;       // Stop bit
                            tx_state <= TX_STOP;
                        end else begin
                            txd    <= tx_data[0];
                            tx_bit <= tx_bit + 3'd1;
                        end
                    end
                    TX_STOP: begin
                        tx_empty <= 1'b1;           // Frame done
                        tx_state <= TX_IDLE;
                    end
                    default: tx_state <= TX_IDLE;
                endcase
            end
        end
    end

    // Receiver runs its own counter, aligned to the start edge
    assign rx_fall   = rxd_d && !rxd_s;
    assign rx_sample = cfg.rx_en && pclk_en && (rx_cnt == 8'd0);

    always_ff @(posedge clk_14m) begin
        if (rx_sample && rx_state == RX_DATA) rx_shift <= {rxd_s, rx_shift[7:1]};
        if (rx_sample && rx_state == RX_STOP && rxd_s) rx_hold <= rx_shift;  // Overwrites
    end

    always_ff @(posedge clk_14m or posedge reset) begin
        if (reset) begin
            rx_state <= RX_IDLE;
            rx_cnt   <= '0;
            rx_bit   <= '0;
            rx_avail <= 1'b0;
            rx_done  <= 1'b0;
        end else begin
            rx_done <= 1'b0;
            if (rd_pop) rx_avail <= 1'b0;
            if (pclk_en && rx_cnt != 8'd0) rx_cnt <= rx_cnt - 8'd1;
            if (rx_sample) rx_cnt <= cfg.time_const;   // Next mid-bit
            if (!cfg.rx_en) begin
                rx_state <= RX_IDLE;
            end else begin
                case (rx_state)
                    RX_IDLE: begin
                        if (rx_fall) begin
                            rx_cnt   <= {1'b0, cfg.time_const[7:1]};  // Half a bit
                            rx_state <= RX_START;
                        end
                    end
                    RX_START: begin
                        if (rx_sample) begin
                            rx_bit   <= 3'd0;
                            rx_state <= rxd_s ? RX_IDLE : RX_DATA;  // Glitch rejected
                        end
                    end
                    RX_DATA: begin
                        if (rx_sample) begin
                            rx_bit <= rx_bit + 3'd1;
                            if (rx_bit == 3'd7) rx_state <= RX_STOP;
                        end
                    end
                    RX_STOP: begin
                        if (rx_sample) begin
                            rx_state <= RX_IDLE;
                            if (rxd_s) begin            // Framing error drops byte
                                rx_avail <= 1'b1;
                                rx_done  <= 1'b1;
                            end
                        end
                    end
                    default: rx_state <= RX_IDLE;
                endcase
            end
        end
    end

    always_comb begin
        stat.rx_avail = rx_avail;
        stat.tx_empty = tx_empty;
        stat.cts      = cts_s;
        stat.rx_byte  = rx_hold;
        stat.rx_done  = rx_done;
    end

    assign rts = !cfg.rts;              // WR5 RTS set drives pin low

endmodule

// File: hw/scc_pkg.sv
package scc_pkg;

    // Register numbers reached through the WR0 pointer
    typedef enum logic [3:0] {
        REG0  = 4'd0,   // WR0 pointer, RR0 status
        REG1  = 4'd1,   // WR1 interrupt enables
        REG3  = 4'd3,   // WR3 receive enable, RR3 pending (A only)
        REG5  = 4'd5,   // WR5 transmit enable and RTS
        REG9  = 4'd9,   // WR9 master interrupt enable
        REG12 = 4'd12   // WR12/RR12 baud time constant
    } scc_reg_e;

    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,
        RX_START = 2'd1,
        RX_DATA  = 2'd2,
        RX_STOP  = 2'd3
    } rx_state_e;

    // Register block to channel
    typedef struct packed {
        logic       tx_en;
        logic       rx_en;
        logic       rts;
        logic [7:0] time_const;   // Bit time is time_const+1 PCLK ticks
        logic       tx_load;      // One cycle, byte rides on tx_byte
    } scc_chan_cfg_t;

    // Channel to register block
    typedef struct packed {
        logic       rx_avail;
        logic       tx_empty;
        logic       cts;
        logic [7:0] rx_byte;
        logic       rx_done;      // One cycle per completed frame
    } scc_chan_stat_t;

    // RR0 bit positions
    localparam int RR0_RX_AVAIL = 0;
    localparam int RR0_TX_EMPTY = 2;
    localparam int RR0_CTS      = 5;

    // Write register bit positions
    localparam int WR1_TX_IE = 1;
    localparam int WR1_RX_IE = 4;
    localparam int WR3_RX_EN = 0;
    localparam int WR5_RTS   = 1;
    localparam int WR5_TX_EN = 3;
    localparam int WR9_MIE   = 3;

endpackage
